// ==== files.f ====
verilog/tc_pkg.sv
verilog/sp_regfile.sv
verilog/tc_ctrl.sv
verilog/tc_gather.sv
verilog/tc_mma_array.sv
verilog/tc_scatter.sv
verilog/tc_sm_top.sv
verification/tc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the tensor-core slice testbench with Verilator and run it.
# The run passes only when the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tc_tb -f files.f \
    && ./obj_dir/Vtc_tb | tee /dev/stderr | grep -qxF '** PASS **' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== verification/tc_tb.sv ====
/*
 Testbench for the tensor-core SM slice
 Shadow register model with directed tests for reset, host
 access, identity, random, wrapping and chained multiplies
*/
`timescale 1ns/1ps
`default_nettype none

module tc_tb
    import tc_pkg::*;
#(
    parameter int CMD_DEPTH   = 2,
    parameter int MMA_LATENCY = 3
);

    localparam int DEPTH       = 16;
    localparam int NUM_RAND    = 10;
    localparam int CMD_CYCLES  = 6 + MMA_LATENCY;
    localparam int NUM_CMDS    = 12 + CMD_DEPTH;
    // Operand loads and full readback per command, plus the host test
    localparam int HOST_CYCLES = 200 * NUM_CMDS + 400;
    localparam int MAX_CYCLES  = 12 * CMD_CYCLES * NUM_CMDS + HOST_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    wmma_cmd_t cmd;
    host_acc_t host;
    logic      busy;
    logic      credit_return;
    elem_t     host_rdata;

    elem_t       shadow [NUM_SP][DEPTH];
    logic [31:0] rng;
    int          cycles;
    int          checks;
    int          errors;
    int          err_mark;
    int          credits;
    int          ret_count;

    tc_sm_top #(
        .CMD_DEPTH  (CMD_DEPTH),
        .MMA_LATENCY(MMA_LATENCY)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .host         (host),
        .busy         (busy),
        .credit_return(credit_return),
        .host_rdata   (host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // Host side credit counter
    always @(posedge clk) begin
        if (credit_return) begin
            ret_count++;
            credits++;
            if (credits > CMD_DEPTH) begin
                errors++;
                $display("A credit came back with no command outstanding");
            end
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic elem_t rand_elem();
        rng = xorshift32(rng);
        return rng[15:0];
    endfunction

    // Register numbers wrap at 16
    function automatic int reg_index(input rf_addr_t base, input int off);
        rf_addr_t r;
        r = base + rf_addr_t'(off);
        return int'(r);
    endfunction

    function automatic wmma_cmd_t make_cmd(input int a, input int b, input int c, input int d);
        wmma_cmd_t m;
        m.a_base = rf_addr_t'(a);
        m.b_base = rf_addr_t'(b);
        m.c_base = rf_addr_t'(c);
        m.d_base = rf_addr_t'(d);
        return m;
    endfunction

    task automatic check_elem(input string name, input elem_t got, input elem_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic host_write(input int sp, input int addr, input elem_t data);
        @(negedge clk);
        host.sp    = 2'(sp);
        host.addr  = rf_addr_t'(addr);
        host.wdata = data;
        host.we    = 1'b1;
        shadow[sp][addr] = data;
        @(negedge clk);
        host.we = 1'b0;
    endtask

    task automatic host_read(input int sp, input int addr, output elem_t data);
        @(negedge clk);
        host.sp   = 2'(sp);
        host.addr = rf_addr_t'(addr);
        host.we   = 1'b0;
        @(posedge clk);
        data = host_rdata;
    endtask

    task automatic check_regs();
        elem_t got;
        for (int t = 0; t < NUM_SP; t++) begin
            for (int r = 0; r < DEPTH; r++) begin
                host_read(t, r, got);
                check_elem($sformatf("host_rdata sp%0d r%0d", t, r), got, shadow[t][r]);
            end
        end
    endtask

    // Registers base..base+3 of every SP, identity puts a one where SP equals column
    task automatic load_operand(input rf_addr_t base, input logic identity);
        elem_t val;
        for (int t = 0; t < NUM_SP; t++) begin
            for (int j = 0; j < ROW_LEN; j++) begin
                if (identity) begin
                    val = (t == j) ? 16'd1 : 16'd0;
                end else begin
                    val = rand_elem();
                end
                host_write(t, reg_index(base, j), val);
            end
        end
    endtask

    // Reference D = A*B + C, all of it gathered before D is written back
    task automatic model_mma(input wmma_cmd_t c);
        elem_t d [NUM_SP][ROW_LEN];
        elem_t acc;
        for (int i = 0; i < NUM_SP; i++) begin
            for (int j = 0; j < ROW_LEN; j++) begin
                acc = shadow[i][reg_index(c.c_base, j)];
                for (int k = 0; k < ROW_LEN; k++) begin
                    acc = acc + shadow[i][reg_index(c.a_base, k)]
                              * shadow[k][reg_index(c.b_base, j)];
                end
                d[i][j] = acc;
            end
        end
        for (int i = 0; i < NUM_SP; i++) begin
            for (int j = 0; j < ROW_LEN; j++) begin
                shadow[i][reg_index(c.d_base, j)] = d[i][j];
            end
        end
    endtask

    task automatic issue_cmd(input wmma_cmd_t c);
        @(negedge clk);
        if (credits == 0) begin
            errors++;
            $display("Tried to issue a command with no credit left");
        end else begin
            cmd_valid = 1'b1;
            cmd       = c;
            credits--;
            model_mma(c);
        end
    endtask

    task automatic stop_issue();
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_returns(input int target);
        while (ret_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic run_cmd(input wmma_cmd_t c);
        int target;
        target = ret_count + 1;
        issue_cmd(c);
        stop_issue();
        // Pop cycle of the command just pushed
        check_bit("busy", busy, 1'b1);
        wait_returns(target);
        check_bit("busy", busy, 1'b0);
    endtask

    task automatic end_test(input string name);
        $display("%-20s %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset();
        elem_t got;
        check_bit("busy", busy, 1'b0);
        check_bit("credit_return", credit_return, 1'b0);
        for (int n = 0; n < 8; n++) begin
            host_read(n % NUM_SP, (5 * n + 3) % DEPTH, got);
            check_elem($sformatf("host_rdata sp%0d", n % NUM_SP), got, 16'h0000);
        end
        end_test("reset");
    endtask

    task automatic test_host();
        for (int t = 0; t < NUM_SP; t++) begin
            for (int r = 0; r < DEPTH; r++) begin
                host_write(t, r, rand_elem());
            end
        end
        check_regs();
        end_test("host access");
    endtask

    task automatic test_identity();
        wmma_cmd_t c;
        c = make_cmd(0, 4, 8, 12);
        load_operand(c.a_base, 1'b0);
        load_operand(c.b_base, 1'b1);
        load_operand(c.c_base, 1'b0);
        run_cmd(c);
        check_regs();
        end_test("identity multiply");
    endtask

    task automatic test_random();
        wmma_cmd_t c;
        for (int n = 0; n < NUM_RAND; n++) begin
            c.a_base = rf_addr_t'(rand_elem());
            c.b_base = rf_addr_t'(rand_elem());
            c.c_base = rf_addr_t'(rand_elem());
            c.d_base = rf_addr_t'(rand_elem());
            load_operand(c.a_base, 1'b0);
            load_operand(c.b_base, 1'b0);
            load_operand(c.c_base, 1'b0);
            run_cmd(c);
            check_regs();
        end
        end_test("random multiply");
    endtask

    task automatic test_wrap();
        wmma_cmd_t c;
        // C reads 14,15,0,1 and D lands on 15,0,1,2
        c = make_cmd(4, 8, 14, 15);
        load_operand(c.a_base, 1'b0);
        load_operand(c.b_base, 1'b0);
        load_operand(c.c_base, 1'b0);
        run_cmd(c);
        check_regs();
        end_test("address wrap");
    endtask

    task automatic test_chain();
        wmma_cmd_t chain [CMD_DEPTH];
        int        first;
        // D alternates between 12 and 0, each A is the previous D
        for (int n = 0; n < CMD_DEPTH; n++) begin
            chain[n] = make_cmd((n == 0) ? 0 : int'(chain[n-1].d_base), 4, 8,
                                (n % 2 == 0) ? 12 : 0);
        end
        load_operand(chain[0].a_base, 1'b0);
        load_operand(chain[0].b_base, 1'b0);
        load_operand(chain[0].c_base, 1'b0);
        first = ret_count;
        for (int n = 0; n < CMD_DEPTH; n++) begin
            issue_cmd(chain[n]);
        end
        stop_issue();
        wait_returns(first + CMD_DEPTH);
        // Quiet window to catch any extra credit
        repeat (2 * CMD_CYCLES) @(negedge clk);
        check_count("credit_return pulses", ret_count - first, CMD_DEPTH);
        check_count("credits", credits, CMD_DEPTH);
        check_bit("busy", busy, 1'b0);
        check_regs();
        end_test("credits and order");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        host      = '0;
        rng       = 32'hb7e8406b;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        credits   = CMD_DEPTH;
        ret_count = 0;
        for (int t = 0; t < NUM_SP; t++) begin
            for (int r = 0; r < DEPTH; r++) begin
                shadow[t][r] = '0;
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_host();
        test_identity();
        test_random();
        test_wrap();
        test_chain();

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/tc_sm_top.sv ====
/*
 Tensor-core SM slice top level
 Four SP register files around the controller, gather,
 MMA array and scatter blocks
*/
`timescale 1ns/1ps
`default_nettype none

module tc_sm_top
    import tc_pkg::*;
#(
    parameter int CMD_DEPTH   = 2,
    parameter int MMA_LATENCY = 3
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            cmd_valid,
    input  wire wmma_cmd_t cmd,
    input  wire host_acc_t host,
    output logic           busy,
    output logic           credit_return,
    output elem_t          host_rdata
);

    rf_addr_t [ROW_LEN-1:0] rd_addr;
    tc_row_t [NUM_SP-1:0]   rd_data;
    elem_t                  sp_host_rdata [NUM_SP];
    logic [2:0]             gather_sel;
    logic                   mma_start;
    logic                   mma_done;
    logic [1:0]             scat_phase;
    rf_addr_t               d_base;
    tc_matrix_t             mat_a;
    tc_matrix_t             mat_b;
    tc_matrix_t             mat_c;
    tc_matrix_t             mat_d;
    rf_wr_t [NUM_WR-1:0]    wr;

    // ==============================
    // Register files
    // ==============================
    for (genvar g = 0; g < NUM_SP; g++) begin : g_sp
        sp_regfile #(
            .SP_ID(g)
        ) i_rf (
            .clk       (clk),
            .rst_n     (rst_n),
            .rd_addr   (rd_addr),
            .wr        (wr),
            .host      (host),
            .rd_data   (rd_data[g]),
            .host_rdata(sp_host_rdata[g])
        );
    end

    assign host_rdata = sp_host_rdata[host.sp];

    // ==============================
    // Tensor core
    // ==============================
    tc_ctrl #(
        .CMD_DEPTH(CMD_DEPTH)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .mma_done     (mma_done),
        .busy         (busy),
        .credit_return(credit_return),
        .rd_addr      (rd_addr),
        .gather_sel   (gather_sel),
        .mma_start    (mma_start),
        .scat_phase   (scat_phase),
        .d_base       (d_base)
    );

    tc_gather i_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .gather_sel(gather_sel),
        .rd_data   (rd_data),
        .a         (mat_a),
        .b         (mat_b),
        .c         (mat_c)
    );

    tc_mma_array #(
        .MMA_LATENCY(MMA_LATENCY)
    ) i_mma (
        .clk      (clk),
        .rst_n    (rst_n),
        .mma_start(mma_start),
        .a        (mat_a),
        .b        (mat_b),
        .c        (mat_c),
        .mma_done (mma_done),
        .d        (mat_d)
    );

    tc_scatter i_scatter (
        .clk       (clk),
        .rst_n     (rst_n),
        .mma_done  (mma_done),
        .d         (mat_d),
        .scat_phase(scat_phase),
        .d_base    (d_base),
        .wr        (wr)
    );

endmodule

`default_nettype wire

// ==== verilog/tc_scatter.sv ====
/*
 Result scatter
 Holds D and spreads its columns over the three shared
 write ports in two phases
*/
`timescale 1ns/1ps
`default_nettype none

module tc_scatter
    import tc_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 mma_done,
    input  wire tc_matrix_t     d,
    input  wire [1:0]           scat_phase,
    input  wire rf_addr_t       d_base,
    output rf_wr_t [NUM_WR-1:0] wr
);

    tc_matrix_t d_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_q <= '0;
        end else if (mma_done) begin
            d_q <= d;
        end
    end

    // ==============================
    // Port mapping
    // ==============================
    // Port p writes element col of every thread to d_base+col
    // phase 0 covers cols 0..2, phase 1 only col 3
    always_comb begin
        int col;
        wr = '0;
        for (int p = 0; p < NUM_WR; p++) begin
            col = scat_phase[1] ? NUM_WR + p : p;
            if ((scat_phase[0] || scat_phase[1]) && (col < ROW_LEN)) begin
                wr[p].addr = d_base + rf_addr_t'(col);
                wr[p].we   = '1;
                for (int t = 0; t < NUM_SP; t++) begin
                    wr[p].data[t] = d_q.row[t][col];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tc_mma_array.sv ====
/*
 Pipelined 4x4 multiply-accumulate array
 D = A*B + C in wrapping 16-bit arithmetic, MMA_LATENCY
 stages from start to done, one new start per cycle allowed
*/
`timescale 1ns/1ps
`default_nettype none

module tc_mma_array
    import tc_pkg::*;
#(
    // Three or more
    parameter int MMA_LATENCY = 3
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             mma_start,
    input  wire tc_matrix_t a,
    input  wire tc_matrix_t b,
    input  wire tc_matrix_t c,
    output logic            mma_done,
    output tc_matrix_t      d
);

    // Stages after products and pair sums
    localparam int TAIL = MMA_LATENCY - 2;

    // Products, indexed [row][col][k]
    elem_t [NUM_SP-1:0][ROW_LEN-1:0][ROW_LEN-1:0] prod_q;
    tc_matrix_t                                   c1_q;
    logic                                         v1_q;

    // Pair sums, indexed [row][col][half]
    elem_t [NUM_SP-1:0][ROW_LEN-1:0][1:0] pair_q;
    tc_matrix_t                           c2_q;
    logic                                 v2_q;

    tc_matrix_t      d_sum;
    tc_matrix_t      d_pipe [TAIL];
    logic [TAIL-1:0] v_pipe;

    // ==============================
    // Stage 1 products
    // ==============================
    always_ff @(posedge clk) begin
        if (mma_start) begin
            for (int i = 0; i < NUM_SP; i++) begin
                for (int j = 0; j < ROW_LEN; j++) begin
                    for (int k = 0; k < ROW_LEN; k++) begin
                        prod_q[i][j][k] <= a.row[i][k] * b.row[k][j];
                    end
                end
            end
            c1_q <= c;
        end
    end

    // ==============================
    // Stage 2 pair sums
    // ==============================
    always_ff @(posedge clk) begin
        if (v1_q) begin
            for (int i = 0; i < NUM_SP; i++) begin
                for (int j = 0; j < ROW_LEN; j++) begin
                    pair_q[i][j][0] <= prod_q[i][j][0] + prod_q[i][j][1];
                    pair_q[i][j][1] <= prod_q[i][j][2] + prod_q[i][j][3];
                end
            end
            c2_q <= c1_q;
        end
    end

    // Final reduction plus accumulator, carries drop off the top
    always_comb begin
        for (int i = 0; i < NUM_SP; i++) begin
            for (int j = 0; j < ROW_LEN; j++) begin
                d_sum.row[i][j] = pair_q[i][j][0] + pair_q[i][j][1] + c2_q.row[i][j];
            end
        end
    end

    // ==============================
    // Output stages
    // ==============================
    always_ff @(posedge clk) begin
        if (v2_q) begin
            d_pipe[0] <= d_sum;
        end
        for (int s = 1; s < TAIL; s++) begin
            if (v_pipe[s-1]) begin
                d_pipe[s] <= d_pipe[s-1];
            end
        end
    end

    // Valid follows the data down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q   <= 1'b0;
            v2_q   <= 1'b0;
            v_pipe <= '0;
        end else begin
            v1_q      <= mma_start;
            v2_q      <= v1_q;
            v_pipe[0] <= v2_q;
            for (int s = 1; s < TAIL; s++) begin
                v_pipe[s] <= v_pipe[s-1];
            end
        end
    end

    assign d        = d_pipe[TAIL-1];
    assign mma_done = v_pipe[TAIL-1];

endmodule

`default_nettype wire

// ==== verilog/tc_gather.sv ====
/*
 Operand gather latches
 Assembles A, B and C from the four SPs' read words
 and holds each until its next gather
*/
`timescale 1ns/1ps
`default_nettype none

module tc_gather
    import tc_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [2:0]                 gather_sel,
    input  wire tc_row_t [NUM_SP-1:0] rd_data,
    output tc_matrix_t                a,
    output tc_matrix_t                b,
    output tc_matrix_t                c
);

    // Select bit 0 is A, bit 1 B, bit 2 C
    localparam int NUM_MAT = 3;

    tc_matrix_t row_set;
    tc_matrix_t mat_q [NUM_MAT];

    // SP t supplies row t
    always_comb begin
        for (int t = 0; t < NUM_SP; t++) begin
            row_set.row[t] = rd_data[t];
        end
    end

    // ==============================
    // Operand holding registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < NUM_MAT; m++) begin
                mat_q[m] <= '0;
            end
        end else begin
            for (int m = 0; m < NUM_MAT; m++) begin
                if (gather_sel[m]) begin
                    mat_q[m] <= row_set;
                end
            end
        end
    end

    assign a = mat_q[0];
    assign b = mat_q[1];
    assign c = mat_q[2];

endmodule

`default_nettype wire

// ==== verilog/tc_ctrl.sv ====
/*
 Tensor-core controller
 Command FIFO, gather/compute/scatter FSM,
 wrapping operand addresses and credit return
*/
`timescale 1ns/1ps
`default_nettype none

module tc_ctrl
    import tc_pkg::*;
#(
    parameter int CMD_DEPTH = 2
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cmd_valid,
    input  wire wmma_cmd_t         cmd,
    input  wire                    mma_done,
    output logic                   busy,
    output logic                   credit_return,
    output rf_addr_t [ROW_LEN-1:0] rd_addr,
    output logic [2:0]             gather_sel,
    output logic                   mma_start,
    output logic [1:0]             scat_phase,
    output rf_addr_t               d_base
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_GATH_A,
        S_GATH_B,
        S_GATH_C,
        S_COMPUTE,
        S_SCAT0,
        S_SCAT1
    } state_t;

    state_t           state;
    state_t           state_nxt;
    wmma_cmd_t        fifo_mem [CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    wmma_cmd_t        cmd_q;
    rf_addr_t         rd_base;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ==============================
    // Command FIFO
    // ==============================
    // Credits keep the host from pushing into a full FIFO
    assign pop = (state == S_IDLE) && (count != '0);

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (pop) begin
                    state_nxt = S_GATH_A;
                end
            end
            S_GATH_A:  state_nxt = S_GATH_B;
            S_GATH_B:  state_nxt = S_GATH_C;
            S_GATH_C:  state_nxt = S_COMPUTE;
            S_COMPUTE: begin
                if (mma_done) begin
                    state_nxt = S_SCAT0;
                end
            end
            S_SCAT0:   state_nxt = S_SCAT1;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cmd_q     <= '0;
            mma_start <= 1'b0;
        end else begin
            state     <= state_nxt;
            // Start lands in the cycle after C is latched
            mma_start <= (state == S_GATH_C);
            if (pop) begin
                cmd_q <= fifo_mem[rd_ptr];
            end
        end
    end

    // Busy already covers the pop cycle
    assign busy          = (state != S_IDLE) || pop;
    assign credit_return = (state == S_SCAT1);
    assign gather_sel    = {state == S_GATH_C, state == S_GATH_B, state == S_GATH_A};
    assign scat_phase    = {state == S_SCAT1, state == S_SCAT0};
    assign d_base        = cmd_q.d_base;

    // Operand rows at base..base+3, wrapping in 4 bits
    always_comb begin
        case (state)
            S_GATH_B: rd_base = cmd_q.b_base;
            S_GATH_C: rd_base = cmd_q.c_base;
            default:  rd_base = cmd_q.a_base;
        endcase
        for (int j = 0; j < ROW_LEN; j++) begin
            rd_addr[j] = rd_base + rf_addr_t'(j);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sp_regfile.sv ====
/*
 Scalar processor register file
 Sixteen words with four asynchronous gather reads,
 three scatter write ports and one host access port
*/
`timescale 1ns/1ps
`default_nettype none

module sp_regfile
    import tc_pkg::*;
#(
    parameter int SP_ID = 0
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rf_addr_t [ROW_LEN-1:0] rd_addr,
    input  wire rf_wr_t [NUM_WR-1:0]    wr,
    input  wire host_acc_t              host,
    output tc_row_t                     rd_data,
    output elem_t                       host_rdata
);

    localparam int DEPTH = 2 ** $bits(rf_addr_t);
    localparam logic [1:0] HOST_ID = 2'(SP_ID);

    elem_t mem [DEPTH];

    // ==============================
    // Write side
    // ==============================
    // Host traffic only happens with the slice idle, so it never meets a scatter write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_WR; p++) begin
                if (wr[p].we[SP_ID]) begin
                    mem[wr[p].addr] <= wr[p].data[SP_ID];
                end
            end
            if (host.we && (host.sp == HOST_ID)) begin
                mem[host.addr] <= host.wdata;
            end
        end
    end

    // ==============================
    // Read side
    // ==============================
    always_comb begin
        for (int j = 0; j < ROW_LEN; j++) begin
            rd_data[j] = mem[rd_addr[j]];
        end
    end

    assign host_rdata = mem[host.addr];

endmodule

`default_nettype wire

// ==== verilog/tc_pkg.sv ====
/*
 Tensor-core slice shared definitions
 Element and register address types, 4x4 matrix layout,
 WMMA command, scatter write port and host access records
*/
`default_nettype none

package tc_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int NUM_SP  = 4;
    // Words per matrix row, also registers per operand
    localparam int ROW_LEN = 4;
    // Shared scatter write ports
    localparam int NUM_WR  = 3;

    typedef logic [15:0] elem_t;
    typedef logic [3:0]  rf_addr_t;

    // One thread's row, element j at index j
    typedef elem_t [ROW_LEN-1:0] tc_row_t;

    // Row t lives in SP t
    typedef struct packed {
        tc_row_t [NUM_SP-1:0] row;
    } tc_matrix_t;

    typedef struct packed {
        rf_addr_t a_base;
        rf_addr_t b_base;
        rf_addr_t c_base;
        rf_addr_t d_base;
    } wmma_cmd_t;

    // Shared address, per-SP data and enable
    typedef struct packed {
        rf_addr_t           addr;
        elem_t [NUM_SP-1:0] data;
        logic  [NUM_SP-1:0] we;
    } rf_wr_t;

    typedef struct packed {
        logic [1:0] sp;
        rf_addr_t   addr;
        elem_t      wdata;
        logic       we;
    } host_acc_t;

endpackage

`default_nettype wire
